// File: Bender.yml
package:
  name: lsu_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/lsu_data_pkg.sv
      - src/lsu_ctrl_pkg.sv
      - src/lsu_agu.sv
      - src/lsu_wait_timer.sv
      - src/lsu_fsm.sv
      - src/lsu_datapath.sv
      - src/lsu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/lsu_top_props.sv
      - verif/lsu_tb.sv

// File: include/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Width of data words and addresses
`define LSU_XLEN 32

// Cycles of dmem_valid without dmem_ready before a request is abandoned
`define LSU_BUS_TIMEOUT 16

// ----------------------------------------
// Exception cause codes, as mcause encodes them

`define LSU_EXC_INSTR_MISALIGN 4'd0
`define LSU_EXC_LOAD_MISALIGN  4'd4
`define LSU_EXC_LOAD_FAULT     4'd5
`define LSU_EXC_STORE_MISALIGN 4'd6
`define LSU_EXC_STORE_FAULT    4'd7

`endif

// File: lsu_top.f
+incdir+include
src/lsu_data_pkg.sv
src/lsu_ctrl_pkg.sv
src/lsu_agu.sv
src/lsu_wait_timer.sv
src/lsu_fsm.sv
src/lsu_datapath.sv
src/lsu_top.sv
verif/lsu_top_props.sv
verif/lsu_tb.sv

// File: src/lsu_agu.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_agu (
  input  logic                    jal,
  input  logic                    jalr,
  input  logic                    branch,
  input  logic                    auipc,
  input  logic                    load,
  input  logic                    store,
  input  lsu_ctrl_pkg::mem_size_t size,
  input  lsu_data_pkg::word_t     rs1,
  input  lsu_data_pkg::word_t     pc,
  input  lsu_data_pkg::word_t     imm,
  output lsu_data_pkg::word_t     agu_address,
  output lsu_data_pkg::byteen_t   agu_byteen,
  output logic                    mem_access,
  output logic                    misalign,
  output lsu_data_pkg::ecause_t   mis_cause
);

  logic                imem_access;
  logic                base_pc;
  lsu_data_pkg::word_t sum;

  assign imem_access = jal | jalr | branch;
  assign mem_access  = load | store;
  assign base_pc     = auipc | jal | branch; // Targets relative to the pc

  assign sum         = (base_pc ? pc : rs1) + imm;
  assign agu_address = {sum[`LSU_XLEN-1:1], sum[0] & ~jalr}; // Jalr drops bit 0

  // ----------------------------------------
  // Byte lanes and alignment

  always_comb begin
    agu_byteen = 4'hF;
    misalign   = 1'b0;
    mis_cause  = `LSU_EXC_INSTR_MISALIGN;

    if (imem_access) begin
      misalign = |agu_address[1:0]; // No compressed instructions
    end else if (mem_access) begin
      mis_cause = load ? `LSU_EXC_LOAD_MISALIGN : `LSU_EXC_STORE_MISALIGN;
      case (size)
        lsu_ctrl_pkg::SIZE_BYTE: begin
          agu_byteen = 4'b0001 << agu_address[1:0];
        end
        lsu_ctrl_pkg::SIZE_HALF: begin
          agu_byteen = agu_address[1] ? 4'hC : 4'h3;
          misalign   = agu_address[0];
        end
        lsu_ctrl_pkg::SIZE_WORD: begin
          misalign = |agu_address[1:0];
        end
        default: begin
          misalign = 1'b1; // Unknown size is treated as misaligned
        end
      endcase

      if (misalign) begin
        agu_byteen = '0; // Nothing goes to the bus
      end
    end
  end

endmodule

`default_nettype wire

// File: src/lsu_ctrl_pkg.sv
`default_nettype none

package lsu_ctrl_pkg;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_t; // Matches funct3[1:0] of loads and stores

  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_REQ  = 2'd1, // Request is on the bus
    S_DONE = 2'd2
  } lsu_state_t;

endpackage

`default_nettype wire

// File: src/lsu_data_pkg.sv
`default_nettype none

`include "lsu_consts.svh"

package lsu_data_pkg;

  typedef logic [`LSU_XLEN-1:0] word_t; // Address or data word

  typedef logic [`LSU_XLEN/8-1:0] byteen_t; // One bit per byte lane

  typedef logic [3:0] ecause_t; // Exception cause code

endpackage

`default_nettype wire

// File: src/lsu_datapath.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_datapath (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    capture_req,
  input  logic                    capture_rdata,
  input  logic                    fault,
  input  logic                    store,
  input  logic                    unsigned_load,
  input  lsu_ctrl_pkg::mem_size_t size,
  input  lsu_data_pkg::word_t     agu_address,
  input  lsu_data_pkg::word_t     rs2,
  input  lsu_data_pkg::word_t     dmem_rdata,
  input  lsu_data_pkg::byteen_t   agu_byteen,
  input  logic                    misalign,
  input  lsu_data_pkg::ecause_t   mis_cause,
  output lsu_data_pkg::word_t     address,
  output lsu_data_pkg::word_t     dmem_wdata,
  output lsu_data_pkg::word_t     load_data,
  output lsu_data_pkg::word_t     etval,
  output lsu_data_pkg::byteen_t   dmem_byteen,
  output logic                    exception,
  output lsu_data_pkg::ecause_t   ecause
);

  lsu_ctrl_pkg::mem_size_t size_q;
  logic                    unsigned_q;
  logic                    store_q;
  lsu_data_pkg::word_t     lane;
  lsu_data_pkg::word_t     extended;

  // ----------------------------------------
  // Load alignment and extension

  assign lane = dmem_rdata >> {address[1:0], 3'b000}; // Byte offset inside the word

  always_comb begin
    case (size_q)
      lsu_ctrl_pkg::SIZE_BYTE: extended = {{(`LSU_XLEN-8){~unsigned_q & lane[7]}}, lane[7:0]};
      lsu_ctrl_pkg::SIZE_HALF: extended = {{(`LSU_XLEN-16){~unsigned_q & lane[15]}}, lane[15:0]};
      default:                 extended = lane;
    endcase
  end

  // ----------------------------------------
  // Request and result registers

  always_ff @(posedge clock) begin
    if (capture_req) begin
      address     <= agu_address;
      dmem_byteen <= agu_byteen;
      size_q      <= size;
      unsigned_q  <= unsigned_load;
      store_q     <= store;
      case (size)
        lsu_ctrl_pkg::SIZE_BYTE: dmem_wdata <= {4{rs2[7:0]}}; // Every lane sees the byte
        lsu_ctrl_pkg::SIZE_HALF: dmem_wdata <= {2{rs2[15:0]}};
        default:                 dmem_wdata <= rs2;
      endcase
    end
    if (capture_rdata) begin
      load_data <= extended;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      exception <= 1'b0;
      ecause    <= '0;
    end else if (capture_req) begin
      exception <= misalign;
      ecause    <= misalign ? mis_cause : '0;
    end else if (fault) begin
      exception <= 1'b1;
      ecause    <= store_q ? `LSU_EXC_STORE_FAULT : `LSU_EXC_LOAD_FAULT;
    end
  end

  assign etval = address; // Both misalign and fault report the address

endmodule

`default_nettype wire

// File: src/lsu_fsm.sv
`default_nettype none

module lsu_fsm (
  input  logic clock,
  input  logic rst_n,
  input  logic start,
  input  logic mem_access,
  input  logic misalign,
  input  logic store,
  input  logic dmem_ready,
  input  logic expired,
  output logic busy,
  output logic done,
  output logic dmem_valid,
  output logic dmem_write,
  output logic capture_req,
  output logic capture_rdata,
  output logic fault,
  output logic timer_run
);

  lsu_ctrl_pkg::lsu_state_t state;
  lsu_ctrl_pkg::lsu_state_t state_next;
  logic                     write_q;

  assign busy          = (state != lsu_ctrl_pkg::S_IDLE);
  assign done          = (state == lsu_ctrl_pkg::S_DONE);
  assign dmem_valid    = (state == lsu_ctrl_pkg::S_REQ);
  assign dmem_write    = write_q;
  assign timer_run     = dmem_valid; // Timer clears as soon as the request ends

  assign capture_req   = start & ~busy;
  assign capture_rdata = dmem_valid & dmem_ready;
  assign fault         = dmem_valid & ~dmem_ready & expired; // Ready wins a tie

  // ----------------------------------------
  // Next state

  always_comb begin
    state_next = state;
    case (state)
      lsu_ctrl_pkg::S_IDLE: begin
        if (capture_req) begin
          state_next = (mem_access & ~misalign) ? lsu_ctrl_pkg::S_REQ : lsu_ctrl_pkg::S_DONE;
        end
      end
      lsu_ctrl_pkg::S_REQ: begin
        if (dmem_ready | expired) begin
          state_next = lsu_ctrl_pkg::S_DONE;
        end
      end
      lsu_ctrl_pkg::S_DONE: begin
        state_next = lsu_ctrl_pkg::S_IDLE;
      end
      default: begin
        state_next = lsu_ctrl_pkg::S_IDLE;
      end
    endcase
  end

  // ----------------------------------------
  // State and write flag

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state   <= lsu_ctrl_pkg::S_IDLE;
      write_q <= 1'b0;
    end else begin
      state <= state_next;
      if (capture_req) begin
        write_q <= store & mem_access & ~misalign; // Only a store that reaches the bus
      end else if (state_next != lsu_ctrl_pkg::S_REQ) begin
        write_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/lsu_top.sv
`default_nettype none

module lsu_top (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    start,
  input  logic                    jal,
  input  logic                    jalr,
  input  logic                    branch,
  input  logic                    auipc,
  input  logic                    load,
  input  logic                    store,
  input  lsu_ctrl_pkg::mem_size_t size,
  input  logic                    unsigned_load,
  input  lsu_data_pkg::word_t     rs1,
  input  lsu_data_pkg::word_t     pc,
  input  lsu_data_pkg::word_t     imm,
  input  lsu_data_pkg::word_t     rs2,
  output logic                    busy,
  output logic                    done,
  output lsu_data_pkg::word_t     address,
  output logic                    exception,
  output lsu_data_pkg::ecause_t   ecause,
  output lsu_data_pkg::word_t     etval,
  output lsu_data_pkg::word_t     load_data,
  output logic                    dmem_valid,
  output logic                    dmem_write,
  output lsu_data_pkg::word_t     dmem_addr,
  output lsu_data_pkg::byteen_t   dmem_byteen,
  output lsu_data_pkg::word_t     dmem_wdata,
  input  lsu_data_pkg::word_t     dmem_rdata,
  input  logic                    dmem_ready
);

  // ----------------------------------------
  // Internal nets

  logic                  mem_access;
  logic                  misalign;
  lsu_data_pkg::ecause_t mis_cause;
  lsu_data_pkg::word_t   agu_address;
  lsu_data_pkg::byteen_t agu_byteen;
  logic                  capture_req;
  logic                  capture_rdata;
  logic                  fault;
  logic                  timer_run;
  logic                  expired;

  lsu_agu lsu_agu_i (
    .jal         (jal),
    .jalr        (jalr),
    .branch      (branch),
    .auipc       (auipc),
    .load        (load),
    .store       (store),
    .size        (size),
    .rs1         (rs1),
    .pc          (pc),
    .imm         (imm),
    .agu_address (agu_address),
    .agu_byteen  (agu_byteen),
    .mem_access  (mem_access),
    .misalign    (misalign),
    .mis_cause   (mis_cause)
  );

  lsu_fsm lsu_fsm_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .start         (start),
    .mem_access    (mem_access),
    .misalign      (misalign),
    .store         (store),
    .dmem_ready    (dmem_ready),
    .expired       (expired),
    .busy          (busy),
    .done          (done),
    .dmem_valid    (dmem_valid),
    .dmem_write    (dmem_write),
    .capture_req   (capture_req),
    .capture_rdata (capture_rdata),
    .fault         (fault),
    .timer_run     (timer_run)
  );

  lsu_wait_timer lsu_wait_timer_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .run     (timer_run),
    .expired (expired)
  );

  lsu_datapath lsu_datapath_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .capture_req   (capture_req),
    .capture_rdata (capture_rdata),
    .fault         (fault),
    .store         (store),
    .unsigned_load (unsigned_load),
    .size          (size),
    .agu_address   (agu_address),
    .rs2           (rs2),
    .dmem_rdata    (dmem_rdata),
    .agu_byteen    (agu_byteen),
    .misalign      (misalign),
    .mis_cause     (mis_cause),
    .address       (address),
    .dmem_wdata    (dmem_wdata),
    .load_data     (load_data),
    .etval         (etval),
    .dmem_byteen   (dmem_byteen),
    .exception     (exception),
    .ecause        (ecause)
  );

  assign dmem_addr = address; // Bus address is the registered address

endmodule

`default_nettype wire

// File: src/lsu_wait_timer.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_wait_timer (
  input  logic clock,
  input  logic rst_n,
  input  logic run,
  output logic expired
);

  localparam int unsigned count_w = $clog2(`LSU_BUS_TIMEOUT);
  localparam logic [count_w-1:0] last_count = count_w'(`LSU_BUS_TIMEOUT - 1);

  logic [count_w-1:0] count;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (!run) begin
      count <= '0; // Each request starts from zero
    end else begin
      count <= count + 1'b1;
    end
  end

  // Count equals the number of valid cycles already spent
  assign expired = run & (count == last_count);

endmodule

`default_nettype wire

// File: verif/lsu_tb.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [5:0] k_jal    = 6'b100000;
  localparam logic [5:0] k_jalr   = 6'b010000;
  localparam logic [5:0] k_branch = 6'b001000;
  localparam logic [5:0] k_auipc  = 6'b000100;
  localparam logic [5:0] k_load   = 6'b000010;
  localparam logic [5:0] k_store  = 6'b000001;
  localparam int num_ops     = 59;
  localparam int watchdog_ns = (num_ops + 2) * (`LSU_BUS_TIMEOUT + 4) * 20;

  logic                    clock = 1'b0;
  logic                    rst_n = 1'b0;
  logic                    start = 1'b0;
  logic                    jal = 1'b0, jalr = 1'b0, branch = 1'b0, auipc = 1'b0;
  logic                    load = 1'b0, store = 1'b0, unsigned_load = 1'b0;
  lsu_ctrl_pkg::mem_size_t size = lsu_ctrl_pkg::SIZE_WORD;
  lsu_data_pkg::word_t     rs1 = '0, pc = '0, imm = '0, rs2 = '0;
  logic                    dmem_ready = 1'b0;
  lsu_data_pkg::word_t     dmem_rdata = '0;
  logic                    busy, done, exception, dmem_valid, dmem_write;
  lsu_data_pkg::ecause_t   ecause;
  lsu_data_pkg::word_t     address, etval, load_data, dmem_addr, dmem_wdata;
  lsu_data_pkg::byteen_t   dmem_byteen;

  // Memory model state
  logic                    withhold = 1'b0;
  logic                    in_req = 1'b0;
  int                      ready_delay = 0;
  int                      wait_left = 0;
  int                      requests = 0;
  lsu_data_pkg::word_t     seen_addr = '0, seen_wdata = '0;
  lsu_data_pkg::byteen_t   seen_byteen = '0;
  logic                    seen_write = 1'b0;

  int errors = 0, checks = 0, tests_run = 0, tests_failed = 0, errors_at_start = 0;

  lsu_top lsu_top_i (.*);

  bind lsu_top lsu_top_props props_i (.*);

  always #10 clock = ~clock;

  // ----------------------------------------
  // Memory model

  function automatic lsu_data_pkg::word_t mem_word(input lsu_data_pkg::word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5ac3_0f96; // Every address bit changes the pattern
  endfunction

  always begin
    @(posedge clock);
    #2;
    dmem_ready = 1'b0;
    if (!dmem_valid) begin
      in_req = 1'b0;
    end else if (!in_req) begin
      in_req    = 1'b1;
      wait_left = ready_delay;
      requests++;
    end
    if (in_req && !withhold) begin
      if (wait_left == 0) begin
        dmem_ready  = 1'b1;
        dmem_rdata  = mem_word(dmem_addr);
        seen_addr   = dmem_addr;
        seen_wdata  = dmem_wdata;
        seen_byteen = dmem_byteen;
        seen_write  = dmem_write;
      end else begin
        wait_left--;
      end
    end
  end

  // ----------------------------------------
  // Checks and reports

  task automatic check(input string name, input lsu_data_pkg::word_t got,
                       input lsu_data_pkg::word_t expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
    end
  endtask

  task automatic end_test(input string name);
    int now_errors;
    now_errors = errors + lsu_top_i.props_i.fail_count;
    tests_run++;
    if (now_errors == errors_at_start) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d new errors", name, now_errors - errors_at_start);
    end
    errors_at_start = now_errors;
  endtask

  task automatic run_op(input logic [5:0] kind, input lsu_ctrl_pkg::mem_size_t sz,
                        input logic uns, input lsu_data_pkg::word_t rs1_v,
                        input lsu_data_pkg::word_t pc_v, input lsu_data_pkg::word_t imm_v,
                        input lsu_data_pkg::word_t rs2_v);
    lsu_data_pkg::word_t target;
    lsu_data_pkg::word_t lanes;
    lsu_data_pkg::word_t exp_wdata;
    lsu_data_pkg::word_t exp_load;
    logic [3:0]          exp_be;
    logic [3:0]          cause;
    logic                bad;
    logic                mem;
    logic                exp_exc;
    int                  req_before;

    target = (((kind & (k_jal | k_branch | k_auipc)) != 0) ? pc_v : rs1_v) + imm_v;
    if (kind == k_jalr) begin
      target[0] = 1'b0;
    end
    lanes     = mem_word(target) >> (8 * target[1:0]); // Addressed lane moves to the bottom
    exp_be    = 4'b1111;
    exp_wdata = rs2_v;
    exp_load  = lanes;
    bad       = (target[1:0] != 2'b00);
    case (sz)
      lsu_ctrl_pkg::SIZE_BYTE: begin
        exp_be    = 4'b0001 << target[1:0];
        exp_wdata = rs2_v[7:0] * 32'h0101_0101;
        exp_load  = uns ? {24'h0, lanes[7:0]} : {{24{lanes[7]}}, lanes[7:0]};
        bad       = 1'b0;
      end
      lsu_ctrl_pkg::SIZE_HALF: begin
        exp_be    = 4'b0011 << target[1:0];
        exp_wdata = rs2_v[15:0] * 32'h0001_0001;
        exp_load  = uns ? {16'h0, lanes[15:0]} : {{16{lanes[15]}}, lanes[15:0]};
        bad       = target[0];
      end
      default: ;
    endcase
    mem   = (kind == k_load) || (kind == k_store);
    bad   = bad && (kind != k_auipc);
    cause = `LSU_EXC_INSTR_MISALIGN;
    if (kind == k_load) begin
      cause = bad ? `LSU_EXC_LOAD_MISALIGN : `LSU_EXC_LOAD_FAULT;
    end else if (kind == k_store) begin
      cause = bad ? `LSU_EXC_STORE_MISALIGN : `LSU_EXC_STORE_FAULT;
    end
    exp_exc = bad || (mem && withhold);

    @(posedge clock);
    #2;
    {jal, jalr, branch, auipc, load, store} = kind;
    size          = sz;
    unsigned_load = uns;
    rs1           = rs1_v;
    pc            = pc_v;
    imm           = imm_v;
    rs2           = rs2_v;
    start         = 1'b1;
    req_before    = requests;
    @(posedge clock);
    #2;
    start = 1'b0;
    #1;
    while (!done) begin
      @(posedge clock);
      #1;
    end

    check("busy", busy, 1'b1);
    check("address", address, target);
    check("exception", exception, exp_exc);
    if (exp_exc) begin
      check("ecause", ecause, cause);
      check("etval", etval, target);
      check("dmem_valid", dmem_valid, 1'b0);
    end
    if (bad || !mem) begin
      check("request count", requests, req_before);
    end else if (!withhold) begin
      check("dmem_addr", seen_addr, target);
      check("dmem_byteen", seen_byteen, exp_be);
      check("dmem_write", seen_write, kind == k_store);
      if (kind == k_store) begin
        check("dmem_wdata", seen_wdata, exp_wdata);
      end else begin
        check("load_data", load_data, exp_load);
      end
    end
  endtask

  // ----------------------------------------
  // Stimulus

  initial begin
    void'($urandom(32'hbfdb_b200));
    repeat (4) @(posedge clock);
    #2;
    rst_n = 1'b1;
    #1;
    check("busy", busy, 1'b0);
    check("done", done, 1'b0);
    check("dmem_valid", dmem_valid, 1'b0);
    check("dmem_write", dmem_write, 1'b0);
    check("exception", exception, 1'b0);
    end_test("reset");

    run_op(k_jal, lsu_ctrl_pkg::SIZE_WORD, 1'b0, 32'h0, 32'h0000_1000, 32'h0000_0040, 32'h0);
    run_op(k_jal, lsu_ctrl_pkg::SIZE_WORD, 1'b0, 32'h0, 32'h0000_1000, 32'h0000_0042, 32'h0);
    run_op(k_jalr, lsu_ctrl_pkg::SIZE_WORD, 1'b0, 32'h0000_2001, 32'h0, 32'h0000_0010, 32'h0);
    run_op(k_jalr, lsu_ctrl_pkg::SIZE_WORD, 1'b0, 32'h0000_2002, 32'h0, 32'h0000_0001, 32'h0);
    run_op(k_branch, lsu_ctrl_pkg::SIZE_WORD, 1'b0, 32'h0, 32'h8000_0ffc, 32'hffff_fff0, 32'h0);
    run_op(k_auipc, lsu_ctrl_pkg::SIZE_WORD, 1'b0, 32'h0, 32'h0000_0105, 32'h0001_2000, 32'h0);
    end_test("jumps");

    ready_delay = 1;
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 4; off += (1 << s)) begin
        for (int u = 0; u < 2; u++) begin
          run_op(k_load, lsu_ctrl_pkg::mem_size_t'(s), u[0], $urandom & 32'hffff_fffc, 32'h0,
                 off, 32'h0);
        end
      end
    end
    end_test("loads");

    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 4; off += (1 << s)) begin
        run_op(k_store, lsu_ctrl_pkg::mem_size_t'(s), 1'b0, 32'h0000_4000, 32'h0, off, $urandom);
      end
    end
    end_test("stores");

    for (int s = 1; s < 3; s++) begin
      for (int off = 1; off < 4; off++) begin
        if (off != 2 || s == 2) begin // Half at offset 2 is legal
          run_op(k_load, lsu_ctrl_pkg::mem_size_t'(s), 1'b0, 32'h0000_8000, 32'h0, off, 32'h0);
          run_op(k_store, lsu_ctrl_pkg::mem_size_t'(s), 1'b0, 32'h0000_8000, 32'h0, off,
                 32'h1234_5678);
        end
      end
    end
    end_test("misalign");

    withhold = 1'b1;
    run_op(k_load, lsu_ctrl_pkg::SIZE_WORD, 1'b0, 32'h0000_0100, 32'h0, 32'h0000_0020, 32'h0);
    run_op(k_store, lsu_ctrl_pkg::SIZE_HALF, 1'b0, 32'h0000_0100, 32'h0, 32'h0000_0022,
           32'hcafe_f00d);
    withhold = 1'b0;
    end_test("timeout");

    repeat (20) begin : random_ops
      int s;
      int off;
      logic is_store;
      logic uns;
      lsu_data_pkg::word_t base;
      lsu_data_pkg::word_t data;
      s           = $urandom_range(2, 0);
      off         = $urandom_range(3, 0) & ~((1 << s) - 1);
      is_store    = $urandom_range(1, 0);
      uns         = $urandom_range(1, 0);
      base        = $urandom & 32'hffff_fffc;
      data        = $urandom;
      ready_delay = $urandom_range(`LSU_BUS_TIMEOUT - 4, 0);
      run_op(is_store ? k_store : k_load, lsu_ctrl_pkg::mem_size_t'(s), uns, base, 32'h0, off,
             data);
    end
    end_test("random");

    $display("tests %0d, failed %0d, checks %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, checks, errors, lsu_top_i.props_i.fail_count);
    if (errors == 0 && lsu_top_i.props_i.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/lsu_top_props.sv
`default_nettype none

`include "lsu_consts.svh"

module lsu_top_props (
  input logic                  clock,
  input logic                  rst_n,
  input logic                  start,
  input logic                  busy,
  input logic                  done,
  input logic                  mem_access,
  input logic                  misalign,
  input logic                  dmem_valid,
  input logic                  dmem_ready,
  input logic                  dmem_write,
  input lsu_data_pkg::word_t   dmem_addr,
  input lsu_data_pkg::word_t   dmem_wdata,
  input lsu_data_pkg::byteen_t dmem_byteen
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // ----------------------------------------
  // Bus protocol

  hold_request: assert property (@(posedge clock) disable iff (!rst_n)
    dmem_valid && !dmem_ready |=> !dmem_valid || ($stable(dmem_addr) && $stable(dmem_wdata)
      && $stable(dmem_byteen) && $stable(dmem_write)))
    else begin
      fail_count++;
      $error("request fields changed while the memory stalled");
    end

  done_after_handshake: assert property (@(posedge clock) disable iff (!rst_n)
    dmem_valid && dmem_ready |=> done && !dmem_valid)
    else begin
      fail_count++;
      $error("done did not follow the completing cycle");
    end

  // Misaligned and non-memory operations finish without touching the bus
  no_request: assert property (@(posedge clock) disable iff (!rst_n)
    start && !busy && !(mem_access && !misalign) |=> done && !dmem_valid)
    else begin
      fail_count++;
      $error("a request appeared for an operation that must not reach memory");
    end

  timeout_drop: assert property (@(posedge clock) disable iff (!rst_n)
    dmem_valid [*`LSU_BUS_TIMEOUT] |=> !dmem_valid)
    else begin
      fail_count++;
      $error("dmem_valid stayed high past the bus timeout");
    end

endmodule

`default_nettype wire
